// ==== logic/mem_pkg.sv ====
// Data memory subsystem types
`default_nettype none

package mem_pkg;

   // address fields: tag [15:11], index [10:3], word [2:1], bit 0 zero
   localparam int TAG_W      = 5;
   localparam int INDEX_W    = 8;
   localparam int WORD_W     = 2;
   // words per line, also the number of banks
   localparam int LINE_WORDS = 4;

   typedef enum logic {
      op_read  = 1'b0,
      op_write = 1'b1
   } mem_op_e;

   typedef struct packed {
      mem_op_e     op;
      logic [15:0] addr;
      logic [15:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic [15:0] rdata;
      logic        hit;
      logic        err;
   } mem_rsp_t;

   // one access to the banked memory
   typedef struct packed {
      logic        wr;
      logic [15:0] addr;
      logic [15:0] wdata;
   } bank_req_t;

   typedef enum logic [3:0] {
      st_idle,
      st_lookup,
      st_wb,
      st_alloc,
      st_fill_wait,
      st_finish,
      st_respond,
      st_error
   } ctrl_state_e;

   function automatic logic [TAG_W-1:0] addr_tag(input logic [15:0] addr);
      return addr[15 -: TAG_W];
   endfunction

   function automatic logic [INDEX_W-1:0] addr_index(input logic [15:0] addr);
      return addr[WORD_W+1 +: INDEX_W];
   endfunction

   function automatic logic [WORD_W-1:0] addr_word(input logic [15:0] addr);
      return addr[1 +: WORD_W];
   endfunction

endpackage

`default_nettype wire

// ==== logic/cache_store.sv ====
// Direct-mapped cache arrays
`timescale 1ns/10ps
`default_nettype none

module cache_store (
   input  wire                                  clk,
   input  wire                                  rst_n,
   input  wire                                  rd_en,
   input  wire                                  wr_en,
   input  wire                                  set_tag,
   input  wire [mem_pkg::INDEX_W-1:0]           index,
   input  wire [mem_pkg::WORD_W-1:0]            word,
   input  wire [15:0]                           wdata,
   input  wire [mem_pkg::TAG_W-1:0]             tag,
   input  wire                                  dirty,
   output logic [mem_pkg::LINE_WORDS-1:0][15:0] line_data,
   output logic [mem_pkg::TAG_W-1:0]            line_tag,
   output logic                                 line_valid,
   output logic                                 line_dirty
);

   localparam int LINES = 2 ** mem_pkg::INDEX_W;

   logic [mem_pkg::LINE_WORDS-1:0][15:0] data_q [LINES];
   logic [mem_pkg::TAG_W-1:0]            tag_q  [LINES];
   logic [LINES-1:0]                     valid_q;
   logic [LINES-1:0]                     dirty_q;

   ////////////////////////////////////////////////////////////////////////////
   // line state
   ////////////////////////////////////////////////////////////////////////////

   // set_tag marks the line valid and loads its dirty bit
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (set_tag) begin
         valid_q[index] <= 1'b1;
         dirty_q[index] <= dirty;
      end
   end

   // tag and data arrays
   always_ff @(posedge clk) begin
      if (set_tag) begin
         tag_q[index] <= tag;
      end
      if (wr_en) begin
         data_q[index][word] <= wdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read port
   ////////////////////////////////////////////////////////////////////////////

   // whole line held until the next read, victim streams out of it
   always_ff @(posedge clk) begin
      if (rd_en) begin
         line_data  <= data_q[index];
         line_tag   <= tag_q[index];
         line_valid <= valid_q[index];
         line_dirty <= dirty_q[index];
      end
   end

endmodule

`default_nettype wire

// ==== logic/banked_mem.sv ====
// Four-bank interleaved main memory
`timescale 1ns/10ps
`default_nettype none

module banked_mem #(
   parameter int mem_latency = 3
) (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         mb_valid,
   input  wire mem_pkg::bank_req_t     mb_req,
   output logic                        mb_ready,
   output logic                        rd_valid,
   output logic [15:0]                 rd_data,
   output logic [mem_pkg::WORD_W-1:0]  rd_word
);

   localparam int ROW_W = mem_pkg::TAG_W + mem_pkg::INDEX_W;
   localparam int ROWS  = 2 ** ROW_W;
   localparam int CNT_W = $clog2(mem_latency + 1);

   logic [mem_pkg::WORD_W-1:0]                  bank_sel;
   logic [ROW_W-1:0]                            row;
   logic                                        accept;
   logic [mem_pkg::LINE_WORDS-1:0][CNT_W-1:0]   busy_q;
   logic [mem_pkg::LINE_WORDS-1:0][15:0]        bank_rdata;
   logic [mem_latency-1:0]                      pipe_valid;
   logic [mem_latency-1:0][mem_pkg::WORD_W-1:0] pipe_word;

   // word interleave: bits 2:1 pick the bank, the rest is the row
   assign bank_sel = mem_pkg::addr_word(mb_req.addr);
   assign row      = {mem_pkg::addr_tag(mb_req.addr), mem_pkg::addr_index(mb_req.addr)};
   assign mb_ready = (busy_q[bank_sel] == '0);
   assign accept   = mb_valid && mb_ready;

   ////////////////////////////////////////////////////////////////////////////
   // banks
   ////////////////////////////////////////////////////////////////////////////

   for (genvar b = 0; b < mem_pkg::LINE_WORDS; b++) begin : g_bank
      logic [15:0] words_q [ROWS] = '{default: 16'h0000};
      logic [15:0] rdata_q;

      // read data stays put while the bank is busy
      always_ff @(posedge clk) begin
         if (accept && bank_sel == mem_pkg::WORD_W'(b)) begin
            if (mb_req.wr) begin
               words_q[row] <= mb_req.wdata;
            end else begin
               rdata_q <= words_q[row];
            end
         end
      end

      assign bank_rdata[b] = rdata_q;
   end

   // busy down-counters, one per bank
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q <= '0;
      end else begin
         for (int b = 0; b < mem_pkg::LINE_WORDS; b++) begin
            if (accept && bank_sel == mem_pkg::WORD_W'(b)) begin
               busy_q[b] <= CNT_W'(mem_latency);
            end else if (busy_q[b] != '0) begin
               busy_q[b] <= busy_q[b] - 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read return pipeline
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pipe_valid <= '0;
      end else begin
         pipe_valid[0] <= accept && !mb_req.wr;
         for (int i = 1; i < mem_latency; i++) begin
            pipe_valid[i] <= pipe_valid[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      pipe_word[0] <= bank_sel;
      for (int i = 1; i < mem_latency; i++) begin
         pipe_word[i] <= pipe_word[i-1];
      end
   end

   assign rd_valid = pipe_valid[mem_latency-1];
   assign rd_word  = pipe_word[mem_latency-1];
   assign rd_data  = bank_rdata[rd_word];

endmodule

`default_nettype wire

// ==== logic/cache_ctrl.sv ====
// Cache controller FSM
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl #(
   parameter int mem_latency = 3
) (
   input  wire                                  clk,
   input  wire                                  rst_n,
   input  wire                                  req_valid,
   input  wire mem_pkg::mem_req_t               req,
   input  wire                                  rsp_ready,
   input  wire [mem_pkg::LINE_WORDS-1:0][15:0]  line_data,
   input  wire [mem_pkg::TAG_W-1:0]             line_tag,
   input  wire                                  line_valid,
   input  wire                                  line_dirty,
   input  wire                                  mb_ready,
   input  wire                                  rd_valid,
   input  wire [15:0]                           rd_data,
   input  wire [mem_pkg::WORD_W-1:0]            rd_word,
   output logic                                 req_ready,
   output logic                                 rsp_valid,
   output mem_pkg::mem_rsp_t                    rsp,
   output logic                                 cs_rd_en,
   output logic                                 cs_wr_en,
   output logic                                 cs_set_tag,
   output logic [mem_pkg::INDEX_W-1:0]          cs_index,
   output logic [mem_pkg::WORD_W-1:0]           cs_word,
   output logic [15:0]                          cs_wdata,
   output logic [mem_pkg::TAG_W-1:0]            cs_tag,
   output logic                                 cs_dirty,
   output logic                                 mb_valid,
   output mem_pkg::bank_req_t                   mb_req
);

   localparam int BEAT_W = $clog2(mem_pkg::LINE_WORDS + 1);

   mem_pkg::ctrl_state_e        state_q;
   mem_pkg::ctrl_state_e        state_d;
   mem_pkg::mem_req_t           req_q;
   mem_pkg::mem_rsp_t           rsp_q;
   logic [mem_pkg::TAG_W-1:0]   req_tag;
   logic [mem_pkg::INDEX_W-1:0] req_index;
   logic [mem_pkg::WORD_W-1:0]  req_word;
   logic [mem_pkg::WORD_W-1:0]  wcnt_q;
   logic [BEAT_W-1:0]           beat_q;
   logic                        lookup_hit;
   logic                        issue_last;
   logic                        beat_in;
   logic                        fill_last;

   assign req_tag    = mem_pkg::addr_tag(req_q.addr);
   assign req_index  = mem_pkg::addr_index(req_q.addr);
   assign req_word   = mem_pkg::addr_word(req_q.addr);
   assign lookup_hit = line_valid && (line_tag == req_tag);
   // fourth word of a write-back or allocate accepted
   assign issue_last = mb_valid && mb_ready && (wcnt_q == '1);
   assign beat_in    = rd_valid && (state_q == mem_pkg::st_alloc ||
                                    state_q == mem_pkg::st_fill_wait);
   assign fill_last  = beat_in && (beat_q == BEAT_W'(mem_pkg::LINE_WORDS - 1));

   assign req_ready = (state_q == mem_pkg::st_idle);
   assign rsp_valid = (state_q == mem_pkg::st_respond) || (state_q == mem_pkg::st_error);
   assign rsp       = rsp_q;

   ////////////////////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         mem_pkg::st_idle:
            if (req_valid) begin
               state_d = req.addr[0] ? mem_pkg::st_error : mem_pkg::st_lookup;
            end
         mem_pkg::st_lookup:
            if (lookup_hit) begin
               state_d = mem_pkg::st_respond;
            end else if (line_valid && line_dirty) begin
               state_d = mem_pkg::st_wb;
            end else begin
               state_d = mem_pkg::st_alloc;
            end
         mem_pkg::st_wb:
            if (issue_last) state_d = mem_pkg::st_alloc;
         mem_pkg::st_alloc:
            if (issue_last) state_d = mem_pkg::st_fill_wait;
         mem_pkg::st_fill_wait:
            if (fill_last) state_d = mem_pkg::st_finish;
         mem_pkg::st_finish:
            state_d = mem_pkg::st_respond;
         mem_pkg::st_respond, mem_pkg::st_error:
            if (rsp_ready) state_d = mem_pkg::st_idle;
         default:
            state_d = mem_pkg::st_idle;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // store and memory controls
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      cs_rd_en     = 1'b0;
      cs_wr_en     = 1'b0;
      cs_set_tag   = 1'b0;
      cs_index     = req_index;
      cs_word      = req_word;
      cs_wdata     = req_q.wdata;
      cs_tag       = req_tag;
      cs_dirty     = 1'b0;
      mb_valid     = 1'b0;
      mb_req.wr    = 1'b0;
      mb_req.addr  = {req_tag, req_index, wcnt_q, 1'b0};
      mb_req.wdata = line_data[wcnt_q];
      case (state_q)
         mem_pkg::st_idle: begin
            // lookup read uses the incoming address
            cs_rd_en = req_valid && !req.addr[0];
            cs_index = mem_pkg::addr_index(req.addr);
         end
         mem_pkg::st_wb: begin
            mb_valid    = 1'b1;
            mb_req.wr   = 1'b1;
            mb_req.addr = {line_tag, req_index, wcnt_q, 1'b0};
         end
         mem_pkg::st_alloc, mem_pkg::st_fill_wait: begin
            mb_valid = (state_q == mem_pkg::st_alloc);
            cs_wr_en = rd_valid;
            cs_word  = rd_word;
            cs_wdata = rd_data;
         end
         mem_pkg::st_finish:
            cs_set_tag = 1'b1;
         mem_pkg::st_respond: begin
            // write data merged into the line, marks it dirty
            cs_wr_en   = (req_q.op == mem_pkg::op_write);
            cs_set_tag = (req_q.op == mem_pkg::op_write);
            cs_dirty   = 1'b1;
         end
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= mem_pkg::st_idle;
         wcnt_q  <= '0;
         beat_q  <= '0;
      end else begin
         state_q <= state_d;
         // wraps back to word 0 after each four-word burst
         if (mb_valid && mb_ready) wcnt_q <= wcnt_q + 1'b1;
         if (state_q == mem_pkg::st_lookup) begin
            beat_q <= '0;
         end else if (beat_in) begin
            beat_q <= beat_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         req_q <= req;
         rsp_q <= '{rdata: 16'h0000, hit: 1'b0, err: req.addr[0]};
      end else if (state_q == mem_pkg::st_lookup) begin
         rsp_q <= '{rdata: line_data[req_word], hit: lookup_hit, err: 1'b0};
      end else if (beat_in && rd_word == req_word) begin
         // requested word picked off the fill
         rsp_q.rdata <= rd_data;
      end
   end

endmodule

`default_nettype wire

// ==== logic/mem_system.sv ====
// Data memory subsystem top
`timescale 1ns/10ps
`default_nettype none

module mem_system #(
   parameter int mem_latency = 3
) (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     req_valid,
   input  wire mem_pkg::mem_req_t  req,
   input  wire                     rsp_ready,
   output logic                    req_ready,
   output logic                    rsp_valid,
   output mem_pkg::mem_rsp_t       rsp
);

   // controller to cache store
   logic                                 cs_rd_en;
   logic                                 cs_wr_en;
   logic                                 cs_set_tag;
   logic [mem_pkg::INDEX_W-1:0]          cs_index;
   logic [mem_pkg::WORD_W-1:0]           cs_word;
   logic [15:0]                          cs_wdata;
   logic [mem_pkg::TAG_W-1:0]            cs_tag;
   logic                                 cs_dirty;
   logic [mem_pkg::LINE_WORDS-1:0][15:0] line_data;
   logic [mem_pkg::TAG_W-1:0]            line_tag;
   logic                                 line_valid;
   logic                                 line_dirty;

   // controller to banked memory
   logic                                 mb_valid;
   mem_pkg::bank_req_t                   mb_req;
   logic                                 mb_ready;
   logic                                 rd_valid;
   logic [15:0]                          rd_data;
   logic [mem_pkg::WORD_W-1:0]           rd_word;

   cache_ctrl #(.mem_latency(mem_latency)) u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .rsp_ready  (rsp_ready),
      .line_data  (line_data),
      .line_tag   (line_tag),
      .line_valid (line_valid),
      .line_dirty (line_dirty),
      .mb_ready   (mb_ready),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .rd_word    (rd_word),
      .req_ready  (req_ready),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .cs_rd_en   (cs_rd_en),
      .cs_wr_en   (cs_wr_en),
      .cs_set_tag (cs_set_tag),
      .cs_index   (cs_index),
      .cs_word    (cs_word),
      .cs_wdata   (cs_wdata),
      .cs_tag     (cs_tag),
      .cs_dirty   (cs_dirty),
      .mb_valid   (mb_valid),
      .mb_req     (mb_req)
   );

   cache_store u_store (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_en      (cs_rd_en),
      .wr_en      (cs_wr_en),
      .set_tag    (cs_set_tag),
      .index      (cs_index),
      .word       (cs_word),
      .wdata      (cs_wdata),
      .tag        (cs_tag),
      .dirty      (cs_dirty),
      .line_data  (line_data),
      .line_tag   (line_tag),
      .line_valid (line_valid),
      .line_dirty (line_dirty)
   );

   banked_mem #(.mem_latency(mem_latency)) u_mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .mb_valid (mb_valid),
      .mb_req   (mb_req),
      .mb_ready (mb_ready),
      .rd_valid (rd_valid),
      .rd_data  (rd_data),
      .rd_word  (rd_word)
   );

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
   parameter int half_period  = 2,
   parameter int reset_cycles = 16
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // release just after an edge, away from the sampling point
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== sim/mem_system_assert.sv ====
// Controller handshake assertions
`timescale 1ns/10ps
`default_nettype none

module mem_system_assert #(
   parameter int mem_latency = 3
) (
   input wire                    clk,
   input wire                    rst_n,
   input wire                    req_valid,
   input wire                    req_ready,
   input wire                    rsp_valid,
   input wire                    rsp_ready,
   input wire mem_pkg::mem_rsp_t rsp,
   input wire                    mb_valid,
   input wire                    mb_ready
);

   // consecutive cycles of a refused bank access
   int stall_cnt;
   // set from request acceptance until its response transfers
   logic pending;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stall_cnt <= 0;
      end else if (mb_valid && !mb_ready) begin
         stall_cnt <= stall_cnt + 1;
      end else begin
         stall_cnt <= 0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending <= 1'b0;
      end else if (req_valid && req_ready) begin
         pending <= 1'b1;
      end else if (rsp_valid && rsp_ready) begin
         pending <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // properties
   ////////////////////////////////////////////////////////////////////////////

   rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
      else $error("response changed under back-pressure");

   no_accept_pending: assert property (@(posedge clk) disable iff (!rst_n)
      (pending || rsp_valid) |-> !req_ready)
      else $error("request port open while a response is pending");

   bank_wait_bound: assert property (@(posedge clk) disable iff (!rst_n)
      (mb_valid && !mb_ready) |-> (stall_cnt <= mem_latency))
      else $error("bank access refused for too long");

   quiet_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> (!rsp_valid && !mb_valid))
      else $error("outputs active right after reset");

endmodule

bind cache_ctrl mem_system_assert #(.mem_latency(mem_latency)) u_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .req_valid (req_valid),
   .req_ready (req_ready),
   .rsp_valid (rsp_valid),
   .rsp_ready (rsp_ready),
   .rsp       (rsp),
   .mb_valid  (mb_valid),
   .mb_ready  (mb_ready)
);

`default_nettype wire

// ==== sim/mem_system_tb.sv ====
// Memory subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module mem_system_tb;

   localparam int mem_latency  = 3;
   // directed requests plus the random run
   localparam int num_requests = 412;

   logic              clk;
   logic              rst_n;
   logic              req_valid;
   mem_pkg::mem_req_t req;
   logic              rsp_ready;
   logic              req_ready;
   logic              rsp_valid;
   mem_pkg::mem_rsp_t rsp;

   // reference model of word memory plus tag and valid per line
   logic [15:0] model_mem [32768];
   logic [4:0]  tbl_tag   [256];
   logic        tbl_valid [256];

   int err_count;
   int tests_passed;
   int tests_failed;

   clk_gen u_clk (
      .clk   (clk),
      .rst_n (rst_n)
   );

   mem_system #(.mem_latency(mem_latency)) dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req       (req),
      .rsp_ready (rsp_ready),
      .req_ready (req_ready),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (expected !== actual) begin
         err_count++;
         $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      end
   endtask

   // called and returns 1 ns after a rising edge
   task automatic transact(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
                           input int stall, output mem_pkg::mem_rsp_t got);
      int hold;
      hold      = stall;
      req.op    = wr ? mem_pkg::op_write : mem_pkg::op_read;
      req.addr  = addr;
      req.wdata = wdata;
      req_valid = 1'b1;
      while (!req_ready) begin
         @(posedge clk);
         #1;
      end
      @(posedge clk);
      #1;
      req_valid = 1'b0;
      rsp_ready = (hold == 0);
      // back-pressure counts only cycles with a response waiting
      while (!(rsp_valid && rsp_ready)) begin
         if (rsp_valid) hold--;
         @(posedge clk);
         #1;
         rsp_ready = (hold <= 0);
      end
      got = rsp;
      @(posedge clk);
      #1;
      rsp_ready = 1'b0;
   endtask

   task automatic access_and_check(input logic wr, input logic [15:0] addr,
                                   input logic [15:0] wdata, input int stall);
      mem_pkg::mem_rsp_t got;
      logic [15:0]       exp_rdata;
      logic              exp_hit;
      logic              exp_err;
      logic [4:0]        tag;
      logic [7:0]        idx;
      logic [14:0]       waddr;
      tag       = addr[15:11];
      idx       = addr[10:3];
      waddr     = addr[15:1];
      exp_err   = addr[0];
      exp_hit   = 1'b0;
      exp_rdata = 16'h0000;
      if (!exp_err) begin
         exp_hit        = tbl_valid[idx] && (tbl_tag[idx] == tag);
         exp_rdata      = model_mem[waddr];
         tbl_valid[idx] = 1'b1;
         tbl_tag[idx]   = tag;
         if (wr) model_mem[waddr] = wdata;
      end
      transact(wr, addr, wdata, stall, got);
      check_value("rsp.err", 16'(exp_err), 16'(got.err));
      check_value("rsp.hit", 16'(exp_hit), 16'(got.hit));
      if (exp_err || !wr) check_value("rsp.rdata", exp_rdata, got.rdata);
   endtask

   task automatic report_test(input string label, input int errs_before);
      if (err_count == errs_before) begin
         tests_passed++;
         $display("test %s: ok", label);
      end else begin
         tests_failed++;
         $display("test %s: failed, %0d mismatches", label, err_count - errs_before);
      end
   endtask

   // few tags and indexes so lines conflict often
   task automatic random_traffic(input int count);
      logic [4:0]  tag;
      logic [7:0]  idx;
      logic [1:0]  word;
      logic        odd;
      logic        wr;
      logic [15:0] wdata;
      int          stall;
      for (int i = 0; i < count; i++) begin
         tag   = 5'($urandom_range(0, 3));
         idx   = 8'($urandom_range(0, 3));
         word  = 2'($urandom_range(0, 3));
         odd   = ($urandom_range(0, 15) == 0);
         wr    = ($urandom_range(0, 1) == 1);
         wdata = 16'($urandom);
         stall = ($urandom_range(0, 2) == 0) ? int'($urandom_range(1, 6)) : 0;
         access_and_check(wr, {tag, idx, word, odd}, wdata, stall);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin : main
      int errs_before;
      void'($urandom(81));
      req_valid    = 1'b0;
      req          = '0;
      rsp_ready    = 1'b0;
      err_count    = 0;
      tests_passed = 0;
      tests_failed = 0;
      for (int i = 0; i < 32768; i++) model_mem[i] = 16'h0000;
      for (int i = 0; i < 256; i++) begin
         tbl_tag[i]   = 5'h00;
         tbl_valid[i] = 1'b0;
      end
      wait (rst_n === 1'b1);
      @(posedge clk);
      #1;

      errs_before = err_count;
      check_value("rsp_valid", 16'h0000, 16'(rsp_valid));
      check_value("req_ready", 16'h0001, 16'(req_ready));
      report_test("0 state after reset", errs_before);

      errs_before = err_count;
      access_and_check(1'b0, 16'h0100, 16'h0000, 0);
      access_and_check(1'b0, 16'h0100, 16'h0000, 0);
      report_test("1 cold read then hit", errs_before);

      errs_before = err_count;
      access_and_check(1'b1, 16'h0208, 16'hbeef, 0);
      access_and_check(1'b0, 16'h0208, 16'h0000, 0);
      access_and_check(1'b0, 16'h020a, 16'h0000, 0);
      report_test("2 write then read in line", errs_before);

      // same index with tags 0 and 1
      errs_before = err_count;
      access_and_check(1'b1, 16'h0310, 16'h1234, 0);
      access_and_check(1'b1, 16'h0b10, 16'h5678, 0);
      access_and_check(1'b0, 16'h0310, 16'h0000, 0);
      access_and_check(1'b0, 16'h0b10, 16'h0000, 0);
      report_test("3 dirty eviction", errs_before);

      errs_before = err_count;
      access_and_check(1'b0, 16'h0209, 16'h0000, 0);
      access_and_check(1'b1, 16'h020b, 16'hffff, 2);
      access_and_check(1'b0, 16'h020a, 16'h0000, 0);
      report_test("4 misaligned access", errs_before);

      errs_before = err_count;
      random_traffic(400);
      report_test("5 random traffic", errs_before);

      $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (err_count == 0 && tests_failed == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // forty cycles per request plus reset
   initial begin : watchdog
      #((num_requests * 40 + 16) * 4);
      $display("timeout: run did not finish within the cycle budget for %0d requests",
               num_requests);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/mem_pkg.sv
logic/cache_store.sv
logic/banked_mem.sv
logic/cache_ctrl.sv
logic/mem_system.sv
sim/clk_gen.sv
sim/mem_system_assert.sv
sim/mem_system_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module mem_system_tb -o mem_system_sim

run: compile
	@out="$$(./obj_dir/mem_system_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
